// ==== Makefile ====
# Verilator build and run of the load/store unit testbench

TOP := lsu_tb

all: run

build:
	verilator --binary --timing --assert -f sim.f --top-module $(TOP) -o V$(TOP)

run: build
	./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TESTS FAILED" sim.log; then exit 1; fi
	@grep -q "TESTS PASSED" sim.log

lint:
	verilator --lint-only -Wall --timing -f sim.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== bench/lsu_chk.sv ====
`timescale 1ns/1ns
/* APB checks on the memory side of the arbiter and the writeback pulse
   bound into lsu_top, which sees the arbiter outputs and the core writeback */
module lsu_chk #(
    parameter int ADDR_W = 12
) (
    input logic                     clk,
    input logic                     rst,
    input logic                     m_psel_i,
    input logic                     m_penable_i,
    input logic                     m_pready_i,
    input logic                     m_pwrite_i,
    input logic [ADDR_W:0]          m_paddr_i,
    input logic [lsu_pkg::XLEN-1:0] m_pwdata_i,
    input logic [3:0]               m_pstrb_i,
    input logic                     lsu_pready_i,
    input logic                     host_pready_i,
    input logic                     wb_valid_i
);
    // one wait state, access phase completes on its second cycle
    one_wait_state: assert property (@(posedge clk) disable iff (rst)
        $rose(m_penable_i) |-> !m_pready_i ##1 (m_psel_i && m_penable_i && m_pready_i))
        else $error("memory access did not end after one wait state");

    // fields hold from setup until the completing cycle
    fields_stable: assert property (@(posedge clk) disable iff (rst)
        (m_psel_i && !(m_penable_i && m_pready_i)) |=>
        ($stable(m_paddr_i) && $stable(m_pwrite_i) && $stable(m_pwdata_i)
         && $stable(m_pstrb_i)))
        else $error("memory fields changed before pready");

    // each memory completion reaches exactly one requester
    one_grant: assert property (@(posedge clk) disable iff (rst)
        (m_penable_i && m_pready_i) |-> (lsu_pready_i ^ host_pready_i))
        else $error("memory completion not passed to exactly one requester");

    wb_single_pulse: assert property (@(posedge clk) disable iff (rst)
        wb_valid_i |=> !wb_valid_i)
        else $error("wb_valid_o high two cycles running");

endmodule

bind lsu_top lsu_chk #(.ADDR_W(ADDR_W)) u_chk (
    .clk(clk), .rst(rst),
    .m_psel_i(m_psel), .m_penable_i(m_penable), .m_pready_i(m_pready),
    .m_pwrite_i(m_pwrite), .m_paddr_i(m_paddr), .m_pwdata_i(m_pwdata),
    .m_pstrb_i(m_pstrb), .lsu_pready_i(lsu_pready), .host_pready_i(host_pready_o),
    .wb_valid_i(wb_valid_o)
);

// ==== bench/lsu_tb.sv ====
`timescale 1ns/1ns
/* drives lsu_top on falling edges, expected loads come from a byte reference memory
   memory ops are expected 4 cycles after acceptance when the host is idle */
module lsu_tb;
    localparam int ADDR_W  = 12;
    localparam int TIMEOUT = 50;

    typedef struct {
        int                     grp;
        lsu_pkg::load_type_e    ld;
        lsu_pkg::store_type_e   st;
        logic [31:0]            addr;
        logic [31:0]            data;
        logic [4:0]             rd;
        logic                   exp_err;
        logic                   exp_we;
        int                     exp_lat;
    } op_row_t;

    logic clk;
    logic rst;
    logic op_valid, op_ready, wb_valid, wb_we, wb_err;
    lsu_pkg::load_type_e  load_type;
    lsu_pkg::store_type_e store_type;
    logic [31:0] addr, store_data, wb_data;
    logic [4:0]  rd, wb_rd;
    logic        h_psel, h_penable, h_pwrite, h_pready, h_pslverr;
    logic [ADDR_W:0] h_paddr;
    logic [31:0] h_pwdata, h_prdata;
    logic [3:0]  h_pstrb;

    logic [7:0] ref_mem [0:4095];
    op_row_t    table_q [$];
    int         errors;
    int         checks;
    int         tests;

    lsu_top #(.ADDR_W(ADDR_W)) dut0 (
        .clk(clk), .rst(rst), .op_valid_i(op_valid), .op_ready_o(op_ready),
        .load_type_i(load_type), .store_type_i(store_type), .addr_i(addr),
        .store_data_i(store_data), .rd_i(rd), .wb_valid_o(wb_valid), .wb_we_o(wb_we),
        .wb_err_o(wb_err), .wb_rd_o(wb_rd), .wb_data_o(wb_data),
        .host_psel_i(h_psel), .host_penable_i(h_penable), .host_pwrite_i(h_pwrite),
        .host_paddr_i(h_paddr), .host_pwdata_i(h_pwdata), .host_pstrb_i(h_pstrb),
        .host_prdata_o(h_prdata), .host_pready_o(h_pready), .host_pslverr_o(h_pslverr)
    );

    always #10 clk = ~clk;

    task automatic check_data(input string name, input logic [lsu_pkg::XLEN-1:0] got,
                              input logic [lsu_pkg::XLEN-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic check_rd(input string name, input logic [4:0] got, input logic [4:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
        end
    endtask

    function automatic logic [31:0] ref_word(input logic [31:0] a);
        logic [11:0] base;
        base = {a[11:2], 2'b00};
        return {ref_mem[base+3], ref_mem[base+2], ref_mem[base+1], ref_mem[base]};
    endfunction

    function automatic logic [31:0] expect_load(input lsu_pkg::load_type_e ld,
                                                input logic [31:0] a);
        logic [7:0]  b;
        logic [15:0] h;
        b = ref_mem[a[11:0]];
        h = {ref_mem[a[11:0]+1], ref_mem[a[11:0]]};
        case (ld)
            lsu_pkg::LD_B:  return {{24{b[7]}}, b};
            lsu_pkg::LD_BU: return {24'h0, b};
            lsu_pkg::LD_H:  return {{16{h[15]}}, h};
            lsu_pkg::LD_HU: return {16'h0, h};
            default:        return ref_word(a);
        endcase
    endfunction

    // reference update with the lane strobe shifted by the byte offset
    task automatic apply_store(input lsu_pkg::store_type_e st, input logic [31:0] a,
                               input logic [31:0] d);
        logic [3:0]  strb;
        logic [31:0] lanes;
        strb = (st == lsu_pkg::ST_W) ? lsu_pkg::STRB_W :
               (st == lsu_pkg::ST_H) ? lsu_pkg::STRB_H : lsu_pkg::STRB_B;
        strb = strb << a[1:0];
        lanes = d << (8 * a[1:0]);
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) begin
                ref_mem[{a[11:2], 2'b00} + b] = lanes[8*b +: 8];
            end
        end
    endtask

    task automatic host_xfer(input logic w, input logic [ADDR_W:0] a, input logic [31:0] d,
                             output logic [31:0] rdata, output logic err);
        int n;
        @(negedge clk);
        h_psel = 1'b1;
        h_pwrite = w;
        h_paddr = a;
        h_pwdata = d;
        h_pstrb = w ? 4'hf : 4'h0;
        @(negedge clk);
        h_penable = 1'b1;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!h_pready && n < TIMEOUT);
        if (!h_pready) begin
            errors++;
            $display("timeout at %0t: host transfer got no pready", $time);
        end
        rdata = h_prdata;
        err = h_pslverr;
        @(negedge clk);
        h_psel = 1'b0;
        h_penable = 1'b0;
    endtask

    task automatic host_write(input logic [31:0] a, input logic [31:0] d);
        logic [31:0] rdata;
        logic        err;
        host_xfer(1'b1, a[ADDR_W:0], d, rdata, err);
        apply_store(lsu_pkg::ST_W, a, d);
    endtask

    task automatic host_read_check(input logic [31:0] a);
        logic [31:0] rdata;
        logic        err;
        host_xfer(1'b0, a[ADDR_W:0], 32'h0, rdata, err);
        check_flag("host_pslverr_o", err, 1'b0);
        check_data("host_prdata_o", rdata, ref_word(a));
    endtask

    task automatic run_op(input op_row_t r, output int lat);
        int n;
        n = 0;
        while (!op_ready && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (!op_ready) begin
            errors++;
            $display("timeout at %0t: op_ready_o stayed low", $time);
        end
        op_valid = 1'b1;
        load_type = r.ld;
        store_type = r.st;
        addr = r.addr;
        store_data = r.data;
        rd = r.rd;
        @(negedge clk);
        op_valid = 1'b0;
        // busy from acceptance until the writeback beat
        check_flag("op_ready_o", op_ready, 1'b0);
        lat = 1;
        while (!wb_valid && lat < TIMEOUT) begin
            @(negedge clk);
            lat++;
        end
        if (!wb_valid) begin
            errors++;
            $display("timeout at %0t: no writeback for rd %0d", $time, r.rd);
        end
    endtask

    task automatic apply_row(input op_row_t r, input logic check_lat);
        logic [31:0] exp;
        int          lat;
        exp = (r.ld != lsu_pkg::LD_NONE) ? expect_load(r.ld, r.addr) : r.addr;
        run_op(r, lat);
        check_flag("wb_err_o", wb_err, r.exp_err);
        check_flag("wb_we_o", wb_we, r.exp_we);
        check_rd("wb_rd_o", wb_rd, r.rd);
        if (!r.exp_err && r.st == lsu_pkg::ST_NONE) begin
            check_data("wb_data_o", wb_data, exp);
        end
        if (!r.exp_err && r.st != lsu_pkg::ST_NONE && r.ld == lsu_pkg::LD_NONE) begin
            apply_store(r.st, r.addr, r.data);
        end
        if (check_lat && lat != r.exp_lat) begin
            errors++;
            $display("writeback of rd %0d came after %0d cycles instead of %0d",
                     r.rd, lat, r.exp_lat);
        end
    endtask

    task automatic add_row(input int g, input lsu_pkg::load_type_e ld,
                           input lsu_pkg::store_type_e st, input logic [31:0] a,
                           input logic [4:0] r, input logic e, input logic we, input int lat);
        op_row_t row;
        row = '{g, ld, st, a, $urandom(), r, e, we, lat};
        table_q.push_back(row);
    endtask

    task automatic build_table();
        add_row(1, lsu_pkg::LD_NONE, lsu_pkg::ST_NONE, 32'h1234_5678, 5'd5, 0, 1, 1);
        add_row(1, lsu_pkg::LD_NONE, lsu_pkg::ST_NONE, 32'hffff_0001, 5'd31, 0, 1, 1);
        for (int i = 0; i < 4; i++) begin
            add_row(2, lsu_pkg::LD_B, lsu_pkg::ST_NONE, i, 5'(i + 1), 0, 1, 4);
            add_row(2, lsu_pkg::LD_BU, lsu_pkg::ST_NONE, 4 + i, 5'(i + 8), 0, 1, 4);
        end
        for (int i = 0; i < 4; i += 2) begin
            add_row(2, lsu_pkg::LD_H, lsu_pkg::ST_NONE, i, 5'(i + 12), 0, 1, 4);
            add_row(2, lsu_pkg::LD_HU, lsu_pkg::ST_NONE, 4 + i, 5'(i + 16), 0, 1, 4);
        end
        add_row(2, lsu_pkg::LD_W, lsu_pkg::ST_NONE, 32'h0, 5'd20, 0, 1, 4);
        add_row(2, lsu_pkg::LD_W, lsu_pkg::ST_NONE, 32'h4, 5'd21, 0, 1, 4);
        add_row(3, lsu_pkg::LD_NONE, lsu_pkg::ST_B, 32'h21, 5'd1, 0, 0, 4);
        add_row(3, lsu_pkg::LD_NONE, lsu_pkg::ST_B, 32'h2e, 5'd2, 0, 0, 4);
        add_row(3, lsu_pkg::LD_NONE, lsu_pkg::ST_H, 32'h26, 5'd3, 0, 0, 4);
        add_row(3, lsu_pkg::LD_NONE, lsu_pkg::ST_W, 32'h28, 5'd4, 0, 0, 4);
        add_row(4, lsu_pkg::LD_H, lsu_pkg::ST_NONE, 32'h1, 5'd6, 1, 0, 1);
        add_row(4, lsu_pkg::LD_W, lsu_pkg::ST_NONE, 32'h2, 5'd7, 1, 0, 1);
        add_row(4, lsu_pkg::LD_NONE, lsu_pkg::ST_W, 32'h6, 5'd8, 1, 0, 1);
        add_row(4, lsu_pkg::LD_NONE, lsu_pkg::ST_H, 32'h3, 5'd9, 1, 0, 1);
        add_row(4, lsu_pkg::LD_W, lsu_pkg::ST_W, 32'h0, 5'd10, 1, 0, 1);
        add_row(5, lsu_pkg::LD_W, lsu_pkg::ST_NONE, 32'h1000, 5'd11, 1, 0, 4);
        add_row(5, lsu_pkg::LD_NONE, lsu_pkg::ST_W, 32'h2000, 5'd12, 1, 0, 4);
    endtask

    task automatic apply_group(input int g);
        foreach (table_q[i]) begin
            if (table_q[i].grp == g) begin
                apply_row(table_q[i], 1'b1);
            end
        end
    endtask

    task automatic report(input int num, input string name, input int err_before);
        tests++;
        $display("test %0d %s: %s", num, name, (errors == err_before) ? "ok" : "FAIL");
    endtask

    task automatic mixed_traffic();
        op_row_t r;
        fork
            for (int i = 0; i < 6; i++) begin
                repeat ($urandom_range(0, 3)) @(negedge clk);
                host_write(32'h200 + 4 * i, $urandom());
                host_read_check(32'h200 + 4 * i);
            end
            for (int i = 0; i < 6; i++) begin
                r = '{6, lsu_pkg::LD_NONE, lsu_pkg::ST_W, 32'h100 + 4 * i, $urandom(),
                      5'(i), 0, 0, 4};
                apply_row(r, 1'b0);
                // byte of the word just stored, lane offset walks 0 to 3
                r = '{6, lsu_pkg::LD_B, lsu_pkg::ST_NONE, 32'h100 + 4 * i + (i % 4), 32'h0,
                      5'(i + 20), 0, 1, 4};
                apply_row(r, 1'b0);
            end
        join
    endtask

    initial begin
        logic [31:0] rdata;
        logic        err;
        int          e0;
        void'($urandom(32'hccb68cb6));
        clk = 1'b0;
        rst = 1'b1;
        op_valid = 1'b0;
        load_type = lsu_pkg::LD_NONE;
        store_type = lsu_pkg::ST_NONE;
        addr = '0;
        store_data = '0;
        rd = '0;
        h_psel = 1'b0;
        h_penable = 1'b0;
        h_pwrite = 1'b0;
        h_paddr = '0;
        h_pwdata = '0;
        h_pstrb = '0;
        errors = 0;
        checks = 0;
        tests = 0;
        build_table();
        repeat (5) @(negedge clk);
        rst = 1'b0;

        e0 = errors;
        // idle state straight out of reset
        check_flag("op_ready_o", op_ready, 1'b1);
        check_flag("wb_valid_o", wb_valid, 1'b0);
        apply_group(1);
        report(1, "pass-through", e0);
        e0 = errors;
        // negative and positive byte and half patterns in both words
        host_write(32'h0, 32'h807f_f081);
        host_write(32'h4, 32'h00ff_8001);
        apply_group(2);
        report(2, "loads", e0);
        e0 = errors;
        for (int i = 0; i < 4; i++) begin
            host_write(32'h20 + 4 * i, 32'h1111_1111 * (i + 1));
        end
        apply_group(3);
        for (int i = 0; i < 4; i++) begin
            host_read_check(32'h20 + 4 * i);
        end
        report(3, "stores", e0);
        e0 = errors;
        apply_group(4);
        host_read_check(32'h0);
        host_read_check(32'h4);
        report(4, "misaligned", e0);
        e0 = errors;
        apply_group(5);
        host_xfer(1'b0, 13'h1000, 32'h0, rdata, err);
        check_flag("host_pslverr_o", err, 1'b1);
        report(5, "out of range", e0);
        e0 = errors;
        mixed_traffic();
        report(6, "mixed traffic", e0);

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

// ==== logic/apb_arbiter.sv ====
`timescale 1ns/1ns
/* two APB requesters onto one completer, round robin, unit first after reset
   memory setup is the grant cycle, so a requester already in access waits one cycle */
module apb_arbiter #(
    parameter int ADDR_W = 12
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     lsu_psel_i,
    input  logic                     lsu_penable_i,
    input  logic                     lsu_pwrite_i,
    input  logic [ADDR_W:0]          lsu_paddr_i,
    input  logic [lsu_pkg::XLEN-1:0] lsu_pwdata_i,
    input  logic [3:0]               lsu_pstrb_i,
    output logic [lsu_pkg::XLEN-1:0] lsu_prdata_o,
    output logic                     lsu_pready_o,
    output logic                     lsu_pslverr_o,
    input  logic                     host_psel_i,
    input  logic                     host_penable_i,
    input  logic                     host_pwrite_i,
    input  logic [ADDR_W:0]          host_paddr_i,
    input  logic [lsu_pkg::XLEN-1:0] host_pwdata_i,
    input  logic [3:0]               host_pstrb_i,
    output logic [lsu_pkg::XLEN-1:0] host_prdata_o,
    output logic                     host_pready_o,
    output logic                     host_pslverr_o,
    output logic                     m_psel_o,
    output logic                     m_penable_o,
    output logic                     m_pwrite_o,
    output logic [ADDR_W:0]          m_paddr_o,
    output logic [lsu_pkg::XLEN-1:0] m_pwdata_o,
    output logic [3:0]               m_pstrb_o,
    input  logic [lsu_pkg::XLEN-1:0] m_prdata_i,
    input  logic                     m_pready_i,
    input  logic                     m_pslverr_i
);
    // busy_q marks the memory access phase, owner_q high for the host
    logic busy_q;
    logic owner_q;
    logic lsu_last_q;
    logic pick_host;
    logic sel_host;
    logic done;

    assign pick_host = host_psel_i && (!lsu_psel_i || lsu_last_q);
    assign sel_host  = busy_q ? owner_q : pick_host;

    always_ff @(posedge clk) begin
        if (rst) begin
            busy_q     <= 1'b0;
            owner_q    <= 1'b0;
            lsu_last_q <= 1'b0;
        end else if (!busy_q && (lsu_psel_i || host_psel_i)) begin
            busy_q     <= 1'b1;
            owner_q    <= pick_host;
            lsu_last_q <= !pick_host;
        end else if (done) begin
            busy_q <= 1'b0;
        end
    end

    assign m_psel_o    = busy_q || lsu_psel_i || host_psel_i;
    assign m_penable_o = busy_q;
    assign m_pwrite_o  = sel_host ? host_pwrite_i : lsu_pwrite_i;
    assign m_paddr_o   = sel_host ? host_paddr_i : lsu_paddr_i;
    assign m_pwdata_o  = sel_host ? host_pwdata_i : lsu_pwdata_i;
    assign m_pstrb_o   = sel_host ? host_pstrb_i : lsu_pstrb_i;

    // only the owner in its access phase sees the completion
    assign done           = busy_q && m_pready_i;
    assign lsu_pready_o   = done && !owner_q && lsu_penable_i;
    assign host_pready_o  = done && owner_q && host_penable_i;
    assign lsu_pslverr_o  = lsu_pready_o && m_pslverr_i;
    assign host_pslverr_o = host_pready_o && m_pslverr_i;
    assign lsu_prdata_o   = m_prdata_i;
    assign host_prdata_o  = m_prdata_i;

endmodule

// ==== logic/data_sram.sv ====
`timescale 1ns/1ns
/* APB word memory of 2**(ADDR_W-2) words, one wait state, no reset of contents
   word index at or past the depth writes nothing and returns a slave error */
module data_sram #(
    parameter int ADDR_W = 12
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     psel_i,
    input  logic                     penable_i,
    input  logic                     pwrite_i,
    input  logic [ADDR_W:0]          paddr_i,
    input  logic [lsu_pkg::XLEN-1:0] pwdata_i,
    input  logic [3:0]               pstrb_i,
    output logic [lsu_pkg::XLEN-1:0] prdata_o,
    output logic                     pready_o,
    output logic                     pslverr_o
);
    localparam int DEPTH = 2 ** (ADDR_W - 2);

    logic [lsu_pkg::XLEN-1:0] mem_q [DEPTH];
    logic [lsu_pkg::XLEN-1:0] rdata_q;
    logic [ADDR_W-3:0]        idx;
    logic                     out_of_range;
    logic                     first_access;
    logic                     wait_q;

    assign idx          = paddr_i[ADDR_W-1:2];
    assign out_of_range = (paddr_i[ADDR_W:2] >= (ADDR_W-1)'(DEPTH));
    assign first_access = psel_i && penable_i && !wait_q;

    // wait state, set by the first access cycle
    always_ff @(posedge clk) begin
        if (rst) begin
            wait_q <= 1'b0;
        end else if (first_access) begin
            wait_q <= 1'b1;
        end else if (pready_o) begin
            wait_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (first_access) begin
            if (pwrite_i && !out_of_range) begin
                for (int b = 0; b < 4; b++) begin
                    if (pstrb_i[b]) begin
                        mem_q[idx][8*b +: 8] <= pwdata_i[8*b +: 8];
                    end
                end
            end
            rdata_q <= out_of_range ? '0 : mem_q[idx];
        end
    end

    assign pready_o  = psel_i && penable_i && wait_q;
    assign pslverr_o = pready_o && out_of_range;
    assign prdata_o  = rdata_q;

endmodule

// ==== logic/lsu_core.sv ====
`timescale 1ns/1ns
/* one operation in flight, writeback has no back-pressure
   paddr_o has ADDR_W+1 bits, its top bit flags an address outside the memory */
module lsu_core #(
    parameter int ADDR_W = 12
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     op_valid_i,
    output logic                     op_ready_o,
    input  lsu_pkg::load_type_e      load_type_i,
    input  lsu_pkg::store_type_e     store_type_i,
    input  logic [lsu_pkg::XLEN-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0] store_data_i,
    input  logic [4:0]               rd_i,
    output logic                     wb_valid_o,
    output logic                     wb_we_o,
    output logic                     wb_err_o,
    output logic [4:0]               wb_rd_o,
    output logic [lsu_pkg::XLEN-1:0] wb_data_o,
    output logic                     psel_o,
    output logic                     penable_o,
    output logic                     pwrite_o,
    output logic [ADDR_W:0]          paddr_o,
    output logic [lsu_pkg::XLEN-1:0] pwdata_o,
    output logic [3:0]               pstrb_o,
    input  logic [lsu_pkg::XLEN-1:0] prdata_i,
    input  logic                     pready_i,
    input  logic                     pslverr_i
);
    typedef enum logic [1:0] {S_IDLE, S_SETUP, S_ACCESS, S_WB} state_e;

    state_e                   state_q;
    logic                     accept;
    logic                     is_load;
    logic                     is_store;
    logic                     mem_op;
    logic                     is_half;
    logic                     is_word;
    logic                     op_err;
    logic [3:0]               strb_base;
    lsu_pkg::load_type_e      ld_q;
    logic [1:0]               off_q;
    logic [lsu_pkg::XLEN-1:0] lane;
    logic [lsu_pkg::XLEN-1:0] ext;

    assign op_ready_o = (state_q == S_IDLE);
    assign accept     = op_valid_i && op_ready_o;
    assign is_load    = (load_type_i != lsu_pkg::LD_NONE);
    assign is_store   = (store_type_i != lsu_pkg::ST_NONE);
    assign mem_op     = is_load || is_store;

    // access size, the load code decides when both are set
    always_comb begin
        if (is_load) begin
            is_half = (load_type_i == lsu_pkg::LD_H) || (load_type_i == lsu_pkg::LD_HU);
            is_word = (load_type_i == lsu_pkg::LD_W);
        end else begin
            is_half = (store_type_i == lsu_pkg::ST_H);
            is_word = (store_type_i == lsu_pkg::ST_W);
        end
        strb_base = is_word ? lsu_pkg::STRB_W : (is_half ? lsu_pkg::STRB_H : lsu_pkg::STRB_B);
    end

    // conflicting codes or misaligned address end without a bus access
    assign op_err = (is_load && is_store) || (is_half && addr_i[0])
                  || (is_word && (addr_i[1:0] != 2'b00));

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= S_IDLE;
        end else begin
            case (state_q)
                S_IDLE: begin
                    if (accept) begin
                        state_q <= (mem_op && !op_err) ? S_SETUP : S_WB;
                    end
                end
                S_SETUP:  state_q <= S_ACCESS;
                S_ACCESS: begin
                    if (pready_i) begin
                        state_q <= S_WB;
                    end
                end
                default:  state_q <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ld_q     <= load_type_i;
            off_q    <= addr_i[1:0];
            pwrite_o <= is_store && !is_load;
            // upper address bits fold into the out-of-range bit
            paddr_o  <= {|addr_i[lsu_pkg::XLEN-1:ADDR_W], addr_i[ADDR_W-1:2], 2'b00};
            pwdata_o <= store_data_i << {addr_i[1:0], 3'b000};
            pstrb_o  <= (is_store && !is_load) ? (strb_base << addr_i[1:0]) : 4'b0000;
            wb_rd_o  <= rd_i;
            // pass-through result, replaced after a bus access
            wb_data_o <= addr_i;
            wb_we_o   <= !mem_op;
            wb_err_o  <= op_err;
        end else if (state_q == S_ACCESS && pready_i) begin
            wb_data_o <= pwrite_o ? '0 : ext;
            wb_we_o   <= !pwrite_o && !pslverr_i;
            wb_err_o  <= pslverr_i;
        end
    end

    // addressed lanes moved down to bit 0
    assign lane = prdata_i >> {off_q, 3'b000};

    always_comb begin
        case (ld_q)
            lsu_pkg::LD_B:  ext = {{(lsu_pkg::XLEN-8){lane[7]}}, lane[7:0]};
            lsu_pkg::LD_BU: ext = {{(lsu_pkg::XLEN-8){1'b0}}, lane[7:0]};
            lsu_pkg::LD_H:  ext = {{(lsu_pkg::XLEN-16){lane[15]}}, lane[15:0]};
            lsu_pkg::LD_HU: ext = {{(lsu_pkg::XLEN-16){1'b0}}, lane[15:0]};
            default:        ext = lane;
        endcase
    end

    assign psel_o     = (state_q == S_SETUP) || (state_q == S_ACCESS);
    assign penable_o  = (state_q == S_ACCESS);
    assign wb_valid_o = (state_q == S_WB);

endmodule

// ==== logic/lsu_pkg.sv ====
/* shared widths and operation codes of the load/store unit
   strobes are lane-0 patterns and are shifted by the low address bits */
package lsu_pkg;

    // data and bus width
    localparam int XLEN = 32;

    // load kinds, LD_NONE when the operation reads no memory
    typedef enum logic [2:0] {
        LD_NONE = 3'd0,
        LD_B    = 3'd1,
        LD_H    = 3'd2,
        LD_W    = 3'd3,
        LD_BU   = 3'd4,
        LD_HU   = 3'd5
    } load_type_e;

    // store kinds
    typedef enum logic [1:0] {
        ST_NONE = 2'd0,
        ST_B    = 2'd1,
        ST_H    = 2'd2,
        ST_W    = 2'd3
    } store_type_e;

    // byte lane strobes at lane 0
    localparam logic [3:0] STRB_B = 4'b0001;
    localparam logic [3:0] STRB_H = 4'b0011;
    localparam logic [3:0] STRB_W = 4'b1111;

endpackage

// ==== logic/lsu_top.sv ====
`timescale 1ns/1ns
/* load/store unit and external host port sharing one APB data memory
   host paddr has ADDR_W+1 bits, top bit set addresses past the memory */
module lsu_top #(
    parameter int ADDR_W = 12
) (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     op_valid_i,
    output logic                     op_ready_o,
    input  lsu_pkg::load_type_e      load_type_i,
    input  lsu_pkg::store_type_e     store_type_i,
    input  logic [lsu_pkg::XLEN-1:0] addr_i,
    input  logic [lsu_pkg::XLEN-1:0] store_data_i,
    input  logic [4:0]               rd_i,
    output logic                     wb_valid_o,
    output logic                     wb_we_o,
    output logic                     wb_err_o,
    output logic [4:0]               wb_rd_o,
    output logic [lsu_pkg::XLEN-1:0] wb_data_o,
    input  logic                     host_psel_i,
    input  logic                     host_penable_i,
    input  logic                     host_pwrite_i,
    input  logic [ADDR_W:0]          host_paddr_i,
    input  logic [lsu_pkg::XLEN-1:0] host_pwdata_i,
    input  logic [3:0]               host_pstrb_i,
    output logic [lsu_pkg::XLEN-1:0] host_prdata_o,
    output logic                     host_pready_o,
    output logic                     host_pslverr_o
);
    // unit requester side
    logic                     lsu_psel;
    logic                     lsu_penable;
    logic                     lsu_pwrite;
    logic [ADDR_W:0]          lsu_paddr;
    logic [lsu_pkg::XLEN-1:0] lsu_pwdata;
    logic [3:0]               lsu_pstrb;
    logic [lsu_pkg::XLEN-1:0] lsu_prdata;
    logic                     lsu_pready;
    logic                     lsu_pslverr;
    // memory side
    logic                     m_psel;
    logic                     m_penable;
    logic                     m_pwrite;
    logic [ADDR_W:0]          m_paddr;
    logic [lsu_pkg::XLEN-1:0] m_pwdata;
    logic [3:0]               m_pstrb;
    logic [lsu_pkg::XLEN-1:0] m_prdata;
    logic                     m_pready;
    logic                     m_pslverr;

    lsu_core #(.ADDR_W(ADDR_W)) u_core (
        .clk(clk), .rst(rst),
        .op_valid_i(op_valid_i), .op_ready_o(op_ready_o),
        .load_type_i(load_type_i), .store_type_i(store_type_i),
        .addr_i(addr_i), .store_data_i(store_data_i), .rd_i(rd_i),
        .wb_valid_o(wb_valid_o), .wb_we_o(wb_we_o), .wb_err_o(wb_err_o),
        .wb_rd_o(wb_rd_o), .wb_data_o(wb_data_o),
        .psel_o(lsu_psel), .penable_o(lsu_penable), .pwrite_o(lsu_pwrite),
        .paddr_o(lsu_paddr), .pwdata_o(lsu_pwdata), .pstrb_o(lsu_pstrb),
        .prdata_i(lsu_prdata), .pready_i(lsu_pready), .pslverr_i(lsu_pslverr)
    );

    apb_arbiter #(.ADDR_W(ADDR_W)) u_arb (
        .clk(clk), .rst(rst),
        .lsu_psel_i(lsu_psel), .lsu_penable_i(lsu_penable), .lsu_pwrite_i(lsu_pwrite),
        .lsu_paddr_i(lsu_paddr), .lsu_pwdata_i(lsu_pwdata), .lsu_pstrb_i(lsu_pstrb),
        .lsu_prdata_o(lsu_prdata), .lsu_pready_o(lsu_pready), .lsu_pslverr_o(lsu_pslverr),
        .host_psel_i(host_psel_i), .host_penable_i(host_penable_i),
        .host_pwrite_i(host_pwrite_i), .host_paddr_i(host_paddr_i),
        .host_pwdata_i(host_pwdata_i), .host_pstrb_i(host_pstrb_i),
        .host_prdata_o(host_prdata_o), .host_pready_o(host_pready_o),
        .host_pslverr_o(host_pslverr_o),
        .m_psel_o(m_psel), .m_penable_o(m_penable), .m_pwrite_o(m_pwrite),
        .m_paddr_o(m_paddr), .m_pwdata_o(m_pwdata), .m_pstrb_o(m_pstrb),
        .m_prdata_i(m_prdata), .m_pready_i(m_pready), .m_pslverr_i(m_pslverr)
    );

    data_sram #(.ADDR_W(ADDR_W)) u_sram (
        .clk(clk), .rst(rst),
        .psel_i(m_psel), .penable_i(m_penable), .pwrite_i(m_pwrite),
        .paddr_i(m_paddr), .pwdata_i(m_pwdata), .pstrb_i(m_pstrb),
        .prdata_o(m_prdata), .pready_o(m_pready), .pslverr_o(m_pslverr)
    );

endmodule

// ==== sim.f ====
logic/lsu_pkg.sv
logic/lsu_core.sv
logic/apb_arbiter.sv
logic/data_sram.sv
logic/lsu_top.sv
bench/lsu_chk.sv
bench/lsu_tb.sv
